// File: verilog.f
+incdir+logic
logic/store_pkg.sv
logic/phase_timer.sv
logic/delay_line.sv
logic/read_latch.sv
logic/store_sequencer.sv
logic/processor_store.sv
bench/processor_store_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the store testbench, exit status gives pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module processor_store_tb -f verilog.f \
    && ./obj_dir/Vprocessor_store_tb \
    || { echo "simulation did not pass"; exit 1; }

exit 0

// File: bench/processor_store_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "store_macros.svh"

module processor_store_tb;

    import store_pkg::*;

    localparam int unsigned NUM_CMDS      = 200;
    localparam int unsigned RANDOM_CMDS   = NUM_CMDS - `STORE_WORDS - 4;
    localparam int unsigned TIMEOUT       = NUM_CMDS * 60 + 100;
    localparam int unsigned WRITE_MAX_LAT = 49;
    localparam int unsigned READ_MAX_LAT  = 56;

    logic                    SIM_CLK;
    logic                    rst_n;
    logic                    cmd_valid;
    cmd_t                    cmd;
    logic [1:0]              cmd_chan;
    logic [`WORD_W-1:0]      cmd_word;
    logic                    busy;
    logic                    done;
    logic [`STORE_CHANS-1:0] rsp_flags;

    // reference copy of the store contents
    logic [`STORE_CHANS-1:0] model [`STORE_WORDS];

    logic                    pending;      // an accepted command is in flight
    logic                    idle_before;
    cmd_t                    acc_cmd;
    logic [1:0]              acc_chan;
    logic [`WORD_W-1:0]      acc_word;
    int unsigned             acc_cycle;
    int unsigned             cycle;
    int unsigned             lat;
    int unsigned             dropped;
    logic [`STORE_CHANS-1:0] last_flags;   // result rsp_flags holds between reads

    processor_store i_processor_store (
        .SIM_CLK   (SIM_CLK),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_chan  (cmd_chan),
        .cmd_word  (cmd_word),
        .busy      (busy),
        .done      (done),
        .rsp_flags (rsp_flags)
    );

    initial begin
        SIM_CLK = 1'b0;
        forever #5 SIM_CLK = ~SIM_CLK;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    task automatic problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    function automatic cmd_t pick_cmd(input logic [1:0] sel);
        case (sel)
            2'd0:    return CMD_SET;
            2'd1:    return CMD_CLEAR;
            default: return CMD_READ;
        endcase
    endfunction

    // strobe one command while idle, then wait for its done
    task automatic issue(input cmd_t c, input logic [1:0] ch, input logic [`WORD_W-1:0] w);
        logic [31:0] r;
        cmd_valid <= 1'b1;
        cmd       <= c;
        cmd_chan  <= ch;
        cmd_word  <= w;
        @(posedge SIM_CLK);
        cmd_valid <= 1'b0;
        do begin
            @(posedge SIM_CLK);
            r = $urandom;
            if (!done && r[4:0] == 5'h0) begin
                cmd_valid <= 1'b1;  // lands while busy and must be dropped
                cmd       <= pick_cmd(r[6:5]);
                cmd_chan  <= r[8:7];
                cmd_word  <= r[11:9];
            end else begin
                cmd_valid <= 1'b0;
            end
        end while (!done);
    endtask

    always @(posedge SIM_CLK) begin
        if (rst_n) begin
            cycle = cycle + 1;
            if (cycle > TIMEOUT)
                problem("timeout, the store stopped answering commands");
            assert (busy == pending) else mismatch("busy", 32'(busy), 32'(pending));
            if (!(pending && acc_cmd == CMD_READ))
                assert (rsp_flags == last_flags)
                    else mismatch("rsp_flags", 32'(rsp_flags), 32'(last_flags));
            idle_before = !pending;

            if (done) begin
                assert (pending) else problem("done strobe without an accepted command");
                lat = cycle - acc_cycle;
                if (acc_cmd == CMD_READ) begin
                    assert (lat >= 2 && lat <= READ_MAX_LAT)
                        else mismatch("read latency", lat, READ_MAX_LAT);
                    assert (rsp_flags == model[acc_word])
                        else mismatch("rsp_flags", 32'(rsp_flags), 32'(model[acc_word]));
                    last_flags = model[acc_word];
                end else begin
                    assert (lat >= 2 && lat <= WRITE_MAX_LAT)
                        else mismatch("write latency", lat, WRITE_MAX_LAT);
                    model[acc_word][acc_chan] = (acc_cmd == CMD_SET);
                end
                pending = 1'b0;
            end

            if (cmd_valid && idle_before) begin
                acc_cmd   = cmd;
                acc_chan  = cmd_chan;
                acc_word  = cmd_word;
                acc_cycle = cycle;
                pending   = 1'b1;
            end else if (cmd_valid) begin
                dropped = dropped + 1;
            end
        end
    end

    assert property (@(posedge SIM_CLK) disable iff (!rst_n) done |=> !done)
        else mismatch("done", 32'(done), 32'h0);
    assert property (@(posedge SIM_CLK) disable iff (!rst_n) done |=> !busy)
        else mismatch("busy", 32'(busy), 32'h0);
    assert property (@(posedge SIM_CLK) disable iff (!rst_n) (cmd_valid && !busy) |=> busy)
        else mismatch("busy", 32'(busy), 32'h1);

    initial begin
        logic [31:0] r;
        void'($urandom(32'h2d14_21c0));
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = CMD_SET;
        cmd_chan   = 2'd0;
        cmd_word   = '0;
        pending    = 1'b0;
        cycle      = 0;
        dropped    = 0;
        last_flags = '0;
        for (int i = 0; i < `STORE_WORDS; i++)
            model[i] = '0;

        repeat (5) @(posedge SIM_CLK);
        rst_n <= 1'b1;

        // empty store reads back zero everywhere
        for (int w = 0; w < `STORE_WORDS; w++)
            issue(CMD_READ, 2'd0, `WORD_W'(w));

        issue(CMD_SET, 2'd1, `WORD_W'(3));
        issue(CMD_READ, 2'd0, `WORD_W'(3));
        assert (rsp_flags[1] == 1'b1) else mismatch("rsp_flags[1]", 32'(rsp_flags[1]), 32'h1);
        issue(CMD_CLEAR, 2'd1, `WORD_W'(3));
        issue(CMD_READ, 2'd0, `WORD_W'(3));
        assert (rsp_flags[1] == 1'b0) else mismatch("rsp_flags[1]", 32'(rsp_flags[1]), 32'h0);

        for (int n = 0; n < RANDOM_CMDS; n++) begin
            r = $urandom;
            issue(pick_cmd(r[1:0]), r[3:2], r[6:4]);
        end

        repeat (2) @(posedge SIM_CLK);
        if (dropped > 0) begin
            $display("No errors");
            $finish;
        end else begin
            problem("no command was ever sent while the store was busy");
        end
    end

endmodule
`default_nettype wire

// File: logic/processor_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "store_macros.svh"

module processor_store (
    input  wire                      SIM_CLK,
    input  wire                      rst_n,
    input  wire                      cmd_valid,
    input  wire store_pkg::cmd_t     cmd,
    input  wire [1:0]                cmd_chan,
    input  wire [`WORD_W-1:0]        cmd_word,
    output logic                     busy,
    output logic                     done,
    output logic [`STORE_CHANS-1:0]  rsp_flags
);

    import store_pkg::*;

    phase_t              phase;
    logic [`WORD_W-1:0]  word;
    logic                write_en;
    logic                write_bit;
    logic                latch_clear;
    logic                latch_en;
    logic                line_out;

    // slot timing for the whole store
    phase_timer i_phase_timer (
        .SIM_CLK (SIM_CLK),
        .rst_n   (rst_n),
        .phase   (phase),
        .word    (word)
    );

    store_sequencer i_store_sequencer (
        .SIM_CLK     (SIM_CLK),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_chan    (cmd_chan),
        .cmd_word    (cmd_word),
        .phase       (phase),
        .word        (word),
        .write_en    (write_en),
        .write_bit   (write_bit),
        .latch_clear (latch_clear),
        .latch_en    (latch_en),
        .busy        (busy),
        .done        (done)
    );

    delay_line i_delay_line (
        .SIM_CLK   (SIM_CLK),
        .rst_n     (rst_n),
        .write_en  (write_en),
        .write_bit (write_bit),
        .line_out  (line_out)
    );

    // flags hold until the next read clears them
    read_latch i_read_latch (
        .SIM_CLK     (SIM_CLK),
        .rst_n       (rst_n),
        .phase       (phase),
        .latch_clear (latch_clear),
        .latch_en    (latch_en),
        .line_out    (line_out),
        .rsp_flags   (rsp_flags)
    );

endmodule
`default_nettype wire

// File: logic/store_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "store_macros.svh"

module store_sequencer (
    input  wire                      SIM_CLK,
    input  wire                      rst_n,
    input  wire                      cmd_valid,
    input  wire store_pkg::cmd_t     cmd,
    input  wire [1:0]                cmd_chan,
    input  wire [`WORD_W-1:0]        cmd_word,
    input  wire store_pkg::phase_t   phase,
    input  wire [`WORD_W-1:0]        word,
    output logic                     write_en,
    output logic                     write_bit,
    output logic                     latch_clear,
    output logic                     latch_en,
    output logic                     busy,
    output logic                     done
);

    import store_pkg::*;

    seq_state_t          state;
    seq_state_t          state_nxt;
    cmd_t                cmd_r;
    logic [1:0]          chan_r;
    logic [`WORD_W-1:0]  word_r;
    logic                accept;
    logic                word_hit;
    logic                bit_slot;
    logic                word_start;

    // new commands only get in while idle, anything else is dropped
    assign accept = (state == S_IDLE) && cmd_valid;

    always_ff @(posedge SIM_CLK) begin
        if (accept) begin
            cmd_r  <= cmd;
            chan_r <= cmd_chan;
            word_r <= cmd_word;
        end
    end

    assign word_hit   = (word == word_r);
    assign bit_slot   = word_hit && (phase == chan_phase(chan_r));
    assign word_start = word_hit && (phase == P_V1);

    always_comb begin
        state_nxt   = state;
        write_en    = 1'b0;
        latch_clear = 1'b0;
        latch_en    = 1'b0;

        case (state)
            S_IDLE: begin
                if (accept)
                    state_nxt = S_WAIT_SLOT;
            end

            S_WAIT_SLOT: begin
                case (cmd_r)
                    CMD_SET, CMD_CLEAR: begin
                        if (bit_slot) begin
                            write_en  = 1'b1;  // slot is at the line input now
                            state_nxt = S_DONE;
                        end
                    end
                    CMD_READ: begin
                        if (word_start) begin
                            latch_clear = 1'b1;
                            latch_en    = 1'b1;
                            state_nxt   = S_READ_PASS;
                        end
                    end
                    default: begin
                        state_nxt = S_DONE;  // unknown opcode just retires
                    end
                endcase
            end

            S_READ_PASS: begin
                latch_en = 1'b1;
                if (phase == P_Z4)
                    state_nxt = S_DONE;  // last channel sampled this cycle
            end

            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    // set writes a one, clear a zero
    assign write_bit = (cmd_r == CMD_SET);

    assign busy = (state != S_IDLE);
    assign done = (state == S_DONE);

endmodule
`default_nettype wire

// File: logic/read_latch.sv
`timescale 1ns/1ps
`default_nettype none
`include "store_macros.svh"

module read_latch (
    input  wire                      SIM_CLK,
    input  wire                      rst_n,
    input  wire store_pkg::phase_t   phase,
    input  wire                      latch_clear,
    input  wire                      latch_en,
    input  wire                      line_out,
    output logic [`STORE_CHANS-1:0]  rsp_flags
);

    import store_pkg::*;

    logic [`STORE_CHANS-1:0] chan_hit;

    // each flag samples the line only at its own phase
    always_comb begin
        for (int i = 0; i < `STORE_CHANS; i++) begin
            chan_hit[i] = latch_en && (phase == chan_phase(2'(i)));
        end
    end

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n) begin
            rsp_flags <= '0;
        end else if (latch_clear) begin
            rsp_flags <= '0;  // start of the read pass
        end else begin
            for (int i = 0; i < `STORE_CHANS; i++) begin
                if (chan_hit[i])
                    rsp_flags[i] <= line_out;
            end
        end
    end

endmodule
`default_nettype wire

// File: logic/delay_line.sv
`timescale 1ns/1ps
`default_nettype none
`include "store_macros.svh"

module delay_line (
    input  wire  SIM_CLK,
    input  wire  rst_n,
    input  wire  write_en,
    input  wire  write_bit,
    output logic line_out
);

    logic [`STORE_DELAY-1:0] taps;
    logic                    line_in;

    // recirculation gate, a write replaces the bit of the current slot
    assign line_in = write_en ? write_bit : line_out;

    // oldest stage, same slot the timer shows this cycle
    assign line_out = taps[`STORE_DELAY-1];

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n) begin
            taps <= '0;  // line starts empty
        end else begin
            taps <= {taps[`STORE_DELAY-2:0], line_in};
        end
    end

endmodule
`default_nettype wire

// File: logic/phase_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "store_macros.svh"

module phase_timer (
    input  wire                  SIM_CLK,
    input  wire                  rst_n,
    output store_pkg::phase_t    phase,
    output logic [`WORD_W-1:0]   word
);

    import store_pkg::*;

    phase_t phase_nxt;
    logic   last_phase;

    always_comb begin
        case (phase)
            P_V1:    phase_nxt = P_W4;
            P_W4:    phase_nxt = P_X4;
            P_X4:    phase_nxt = P_Y5;
            P_Y5:    phase_nxt = P_Y6;
            P_Y6:    phase_nxt = P_Z4;
            default: phase_nxt = P_V1;
        endcase
    end

    assign last_phase = (phase == P_Z4);

    always_ff @(posedge SIM_CLK or negedge rst_n) begin
        if (!rst_n) begin
            phase <= P_V1;
            word  <= '0;
        end else begin
            phase <= phase_nxt;
            if (last_phase) begin
                // word index steps once per word time
                if (word == `WORD_W'(`STORE_WORDS - 1))
                    word <= '0;
                else
                    word <= word + `WORD_W'(1);
            end
        end
    end

endmodule
`default_nettype wire

// File: logic/store_pkg.sv
package store_pkg;

    // timing phases of one word time, in order of appearance
    typedef enum logic [2:0] {
        P_V1 = 3'd0,
        P_W4 = 3'd1,
        P_X4 = 3'd2,
        P_Y5 = 3'd3,
        P_Y6 = 3'd4,
        P_Z4 = 3'd5
    } phase_t;

    typedef enum logic [1:0] {
        CMD_SET   = 2'd0,
        CMD_CLEAR = 2'd1,
        CMD_READ  = 2'd2
    } cmd_t;

    typedef enum logic [1:0] {
        S_IDLE      = 2'd0,
        S_WAIT_SLOT = 2'd1,
        S_READ_PASS = 2'd2,
        S_DONE      = 2'd3
    } seq_state_t;

    // V1 and Y6 carry no channel
    function automatic phase_t chan_phase(input logic [1:0] chan);
        case (chan)
            2'd0:    return P_W4;
            2'd1:    return P_X4;
            2'd2:    return P_Y5;
            default: return P_Z4;
        endcase
    endfunction

endpackage

// File: logic/store_macros.svh
`ifndef STORE_MACROS_SVH
`define STORE_MACROS_SVH

// words circulating in the line
`define STORE_WORDS 8

// phases per word time
`define STORE_PHASES 6

// one full revolution, every slot comes back after this many cycles
`define STORE_DELAY (`STORE_WORDS * `STORE_PHASES)

`define STORE_CHANS 4

`define WORD_W 3

`endif
